/* design/rr_pkg.sv */
package rr_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and counts
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN         = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int NUM_REGS     = 1 << REG_ADDR_W;
    localparam int UOP_W        = 8;
    localparam int NUM_WB       = 3;
    localparam int NUM_SRC      = 4;   // rj/rk of both lanes
    localparam int LOAD_LATENCY = 3;   // Load leaving the stage to result on wb[2]
    localparam int TIMER_W      = $clog2(LOAD_LATENCY + 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction bundle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [31:0]           pc;
        logic [31:0]           inst;
        logic [UOP_W-1:0]      uop;
        logic [31:0]           imm;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic                  is_load;   // Lane 0 only
    } lane_t;

    typedef struct packed {
        lane_t [1:0]  lanes;
        logic [31:0]  pc_next;
        logic         pc_taken;
        logic         branch_flag;
        logic         excp_flag;
        logic [6:0]   exception;
        logic [31:0]  badv;
        logic         valid;
    } bundle_t;

    // Source operands of one lane
    typedef struct packed {
        logic [XLEN-1:0] rj_data;
        logic [XLEN-1:0] rk_data;
    } operand_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write-back port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_port_t;

endpackage

/* design/bypass_select.sv */
`timescale 1ns/1ps

module bypass_select (
    input  logic [rr_pkg::NUM_SRC-1:0][rr_pkg::REG_ADDR_W-1:0] src,
    input  rr_pkg::wb_port_t [rr_pkg::NUM_WB-1:0]              wb,
    output logic [rr_pkg::NUM_SRC-1:0]                         hit,
    output logic [rr_pkg::NUM_SRC-1:0][rr_pkg::XLEN-1:0]       data
);

    import rr_pkg::*;

    logic [NUM_SRC-1:0][NUM_WB-1:0] match;

    // Per source and port: a live write to the same nonzero register
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            for (int p = 0; p < NUM_WB; p++) begin
                match[i][p] = wb[p].we && (wb[p].addr != '0) && (wb[p].addr == src[i]);
            end
        end
    end

    // Later ports overwrite earlier ones, so port 2 wins
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            hit[i]  = 1'b0;
            data[i] = '0;
            for (int p = 0; p < NUM_WB; p++) begin
                if (match[i][p]) begin
                    hit[i]  = 1'b1;
                    data[i] = wb[p].data;
                end
            end
        end
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                                                clk,
    input  logic                                                reset,
    input  rr_pkg::wb_port_t [rr_pkg::NUM_WB-1:0]               wb,
    input  logic [rr_pkg::NUM_SRC-1:0][rr_pkg::REG_ADDR_W-1:0]  raddr,
    output logic [rr_pkg::NUM_SRC-1:0][rr_pkg::XLEN-1:0]        rdata
);

    import rr_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    logic [NUM_SRC-1:0]           wt_hit;
    logic [NUM_SRC-1:0][XLEN-1:0] wt_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Same address on several ports: the last assignment (port 2) sticks
            for (int p = 0; p < NUM_WB; p++) begin
                if (wb[p].we && wb[p].addr != '0) begin
                    regs[wb[p].addr] <= wb[p].data;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read side with write-through
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    bypass_select u_write_through (
        .src  (raddr),
        .wb   (wb),
        .hit  (wt_hit),
        .data (wt_data)
    );

    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            if (raddr[i] == '0) begin
                rdata[i] = '0;                 // r0 is hard-wired
            end else if (wt_hit[i]) begin
                rdata[i] = wt_data[i];         // Newest write this cycle
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

endmodule

/* design/load_timer.sv */
`timescale 1ns/1ps

module load_timer (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic start,
    output logic busy,
    output logic last
);

    import rr_pkg::*;

    logic [TIMER_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            count <= '0;
        end else if (start) begin
            count <= TIMER_W'(LOAD_LATENCY);   // Restarts on a later load too
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);
    assign last = (count == TIMER_W'(1));   // Final cycle, result on wb[2]

endmodule

/* design/hazard_fsm.sv */
`timescale 1ns/1ps

module hazard_fsm (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            fire,
    input  rr_pkg::bundle_t fired_bundle,
    input  rr_pkg::bundle_t held_bundle,
    input  logic            timer_last,
    output logic            timer_start,
    output logic            ex_readygo
);

    import rr_pkg::*;

    typedef enum logic {
        RUN,
        WAIT_LOAD
    } state_t;

    state_t                state;
    logic [REG_ADDR_W-1:0] pend_rd;
    logic                  load_fire;
    logic                  depends;

    assign load_fire = fire && fired_bundle.valid && fired_bundle.lanes[0].is_load;
    assign timer_start = load_fire;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state   <= RUN;
            pend_rd <= '0;
        end else if (load_fire) begin
            state   <= WAIT_LOAD;
            pend_rd <= fired_bundle.lanes[0].rd;
        end else if (timer_last) begin
            state   <= RUN;
        end
    end

    // Any of the four sources reads the pending load destination
    always_comb begin
        depends = 1'b0;
        for (int l = 0; l < 2; l++) begin
            if (held_bundle.lanes[l].rj == pend_rd || held_bundle.lanes[l].rk == pend_rd) begin
                depends = 1'b1;
            end
        end
        if (pend_rd == '0) begin
            depends = 1'b0;   // r0 never waits
        end
    end

    assign ex_readygo = held_bundle.valid && !(state == WAIT_LOAD && depends);

endmodule

/* design/rr_ex_reg.sv */
`timescale 1ns/1ps

module rr_ex_reg (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           flush,
    input  logic                                           load,
    input  logic                                           fire,
    input  rr_pkg::bundle_t                                in_bundle,
    input  rr_pkg::operand_t [1:0]                         in_operands,
    input  logic [rr_pkg::NUM_SRC-1:0]                     patch_hit,
    input  logic [rr_pkg::NUM_SRC-1:0][rr_pkg::XLEN-1:0]   patch_data,
    output rr_pkg::bundle_t                                bundle,
    output rr_pkg::operand_t [1:0]                         operands
);

    import rr_pkg::*;

    logic     clear;
    operand_t [1:0] patched;

    // Bundle leaves with nothing behind it: turn into a bubble
    assign clear = reset || flush || (fire && !load);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand patching while held
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Index 2*lane is rj, 2*lane+1 is rk
    always_comb begin
        patched = operands;
        for (int l = 0; l < 2; l++) begin
            if (patch_hit[2*l]) begin
                patched[l].rj_data = patch_data[2*l];
            end
            if (patch_hit[2*l+1]) begin
                patched[l].rk_data = patch_data[2*l+1];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (clear) begin
            bundle   <= '0;
            operands <= '0;
        end else if (load) begin
            bundle   <= in_bundle;
            operands <= in_operands;   // Already covers this cycle's write-back
        end else begin
            operands <= patched;       // Bundle fields hold
        end
    end

endmodule

/* design/rr_stage.sv */
`timescale 1ns/1ps

module rr_stage (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush,
    input  logic                                  reg_readygo,
    input  rr_pkg::bundle_t                       id_bundle,
    output logic                                  reg_allowin,
    input  logic                                  ex_allowin,
    output logic                                  ex_readygo,
    input  rr_pkg::wb_port_t [rr_pkg::NUM_WB-1:0] wb,
    output rr_pkg::bundle_t                       ex_bundle,
    output rr_pkg::operand_t [1:0]                ex_operands
);

    import rr_pkg::*;

    logic                               load;
    logic                               fire;
    logic [NUM_SRC-1:0][REG_ADDR_W-1:0] rd_addr;
    logic [NUM_SRC-1:0][XLEN-1:0]       rd_data;
    logic [NUM_SRC-1:0][REG_ADDR_W-1:0] held_src;
    logic [NUM_SRC-1:0]                 patch_hit;
    logic [NUM_SRC-1:0][XLEN-1:0]       patch_data;
    operand_t [1:0]                     rf_operands;
    logic                               timer_start;
    logic                               timer_busy;
    logic                               timer_last;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign reg_allowin = ex_allowin && (!ex_bundle.valid || ex_readygo);
    assign load        = reg_readygo && reg_allowin;
    assign fire        = ex_bundle.valid && ex_readygo && ex_allowin;

    // Operand order: lane0 rj, lane0 rk, lane1 rj, lane1 rk
    always_comb begin
        for (int l = 0; l < 2; l++) begin
            rd_addr[2*l]          = id_bundle.lanes[l].rj;
            rd_addr[2*l+1]        = id_bundle.lanes[l].rk;
            held_src[2*l]         = ex_bundle.lanes[l].rj;
            held_src[2*l+1]       = ex_bundle.lanes[l].rk;
            rf_operands[l].rj_data = rd_data[2*l];
            rf_operands[l].rk_data = rd_data[2*l+1];
        end
    end

    reg_file u_reg_file (
        .clk   (clk),
        .reset (reset),
        .wb    (wb),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    bypass_select u_bypass (
        .src  (held_src),
        .wb   (wb),
        .hit  (patch_hit),
        .data (patch_data)
    );

    load_timer u_load_timer (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .start (timer_start),
        .busy  (timer_busy),
        .last  (timer_last)
    );

    // The bundle that fires is the one held in the register
    hazard_fsm u_hazard_fsm (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .fire         (fire),
        .fired_bundle (ex_bundle),
        .held_bundle  (ex_bundle),
        .timer_last   (timer_last),
        .timer_start  (timer_start),
        .ex_readygo   (ex_readygo)
    );

    rr_ex_reg u_rr_ex_reg (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .load        (load),
        .fire        (fire),
        .in_bundle   (id_bundle),
        .in_operands (rf_operands),
        .patch_hit   (patch_hit),
        .patch_data  (patch_data),
        .bundle      (ex_bundle),
        .operands    (ex_operands)
    );

endmodule

/* bench/rr_stage_assert.sv */
`timescale 1ns/1ps

module rr_stage_assert (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            ex_allowin,
    input  logic            ex_readygo,
    input  logic            timer_busy,
    input  rr_pkg::bundle_t ex_bundle
);

    import rr_pkg::*;

    // An empty register never offers a bundle to execute
    readygo_needs_valid: assert property (@(posedge clk) disable iff (reset)
        !ex_bundle.valid |-> !ex_readygo)
        else $error("ex_readygo high while the held bundle is invalid");

    // Only operands may change under back-pressure
    hold_when_blocked: assert property (@(posedge clk) disable iff (reset)
        (!ex_allowin && !flush) |=> $stable(ex_bundle))
        else $error("held bundle changed while ex_allowin was low");

    // Register and load timer both cleared
    flush_empties: assert property (@(posedge clk) disable iff (reset)
        flush |=> (ex_bundle == '0 && !timer_busy))
        else $error("register or load timer not empty in the cycle after flush");

endmodule

bind rr_stage rr_stage_assert u_stage_assert (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .ex_allowin (ex_allowin),
    .ex_readygo (ex_readygo),
    .timer_busy (timer_busy),
    .ex_bundle  (ex_bundle)
);

/* bench/rr_stage_tb.sv */
`timescale 1ns/1ps

module rr_stage_tb;

    import rr_pkg::*;

    localparam int NUM_RAW     = 8;   // Bundles in the read-after-write test
    localparam int TEST_CYCLES = 12 + NUM_RAW * 3 + 5 * (2 * LOAD_LATENCY + 14);
    localparam int MAX_CYCLES  = 2 * (10 + TEST_CYCLES);

    logic                     clk;
    logic                     reset;
    logic                     flush;
    logic                     reg_readygo;
    bundle_t                  id_bundle;
    logic                     reg_allowin;
    logic                     ex_allowin;
    logic                     ex_readygo;
    wb_port_t [NUM_WB-1:0]    wb;
    bundle_t                  ex_bundle;
    operand_t [1:0]           ex_operands;

    logic [XLEN-1:0] ref_regs [NUM_REGS];
    logic [31:0]     seed;
    int              errors;
    int              checks;
    int              cycles;

    rr_stage uut (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .reg_readygo (reg_readygo),
        .id_bundle   (id_bundle),
        .reg_allowin (reg_allowin),
        .ex_allowin  (ex_allowin),
        .ex_readygo  (ex_readygo),
        .wb          (wb),
        .ex_bundle   (ex_bundle),
        .ex_operands (ex_operands)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Reference registers, port 2 applied last so it wins
    always @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) ref_regs[r] = '0;
        end else begin
            for (int p = 0; p < NUM_WB; p++) begin
                if (wb[p].we && wb[p].addr != '0) ref_regs[wb[p].addr] = wb[p].data;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic bundle_t make_bundle(input logic [31:0] pc,
                                            input logic [4:0] s0, input logic [4:0] s1,
                                            input logic [4:0] s2, input logic [4:0] s3,
                                            input logic [4:0] rd0, input logic ld);
        bundle_t b;
        b = '0;
        b.valid            = 1'b1;
        b.pc_next          = pc + 32'd8;
        b.lanes[0].pc      = pc;
        b.lanes[1].pc      = pc + 32'd4;
        b.lanes[0].inst    = lcg();
        b.lanes[0].rj      = s0;
        b.lanes[0].rk      = s1;
        b.lanes[1].rj      = s2;
        b.lanes[1].rk      = s3;
        b.lanes[0].rd      = rd0;
        b.lanes[0].we      = 1'b1;
        b.lanes[0].is_load = ld;
        return b;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_operands(input string name, input bundle_t b);
        check_val(name, ref_regs[b.lanes[0].rj], ex_operands[0].rj_data);
        check_val(name, ref_regs[b.lanes[0].rk], ex_operands[0].rk_data);
        check_val(name, ref_regs[b.lanes[1].rj], ex_operands[1].rj_data);
        check_val(name, ref_regs[b.lanes[1].rk], ex_operands[1].rk_data);
    endtask

    // Loads one bundle; with hold set, execute stops taking it
    task automatic load_bundle(input bundle_t b, input logic hold);
        @(posedge clk);
        id_bundle   <= b;
        reg_readygo <= 1'b1;
        @(posedge clk);
        reg_readygo <= 1'b0;
        ex_allowin  <= !hold;
        @(negedge clk);
    endtask

    task automatic drain();
        @(posedge clk);
        ex_allowin <= 1'b1;
        repeat (LOAD_LATENCY + 2) @(posedge clk);
        @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_read_after_write();
        bundle_t b;
        for (int r = 1; r < NUM_REGS; r += NUM_WB) begin
            @(posedge clk);
            for (int p = 0; p < NUM_WB; p++) begin
                wb[p] <= '{we: (r + p < NUM_REGS), addr: 5'(r + p), data: lcg()};
            end
        end
        @(posedge clk);
        wb <= '0;
        for (int k = 0; k < NUM_RAW; k++) begin
            b = make_bundle(32'h1000 + 32'(k * 8), 5'(lcg() >> 9), 5'(lcg() >> 9),
                            5'(lcg() >> 9), (k == 0) ? 5'd0 : 5'(lcg() >> 9), 5'd1, 1'b0);
            load_bundle(b, 1'b0);
            check_val("raw_pc", b.lanes[0].pc, ex_bundle.lanes[0].pc);
            check_operands("raw_operand", b);
        end
        b = make_bundle(32'h1100, 5'd0, 5'd0, 5'd0, 5'd0, 5'd1, 1'b0);
        load_bundle(b, 1'b0);
        check_val("raw_r0", 32'd0, ex_operands[0].rj_data);
        check_val("raw_r0", 32'd0, ex_operands[1].rk_data);
        drain();
    endtask

    task automatic test_write_priority();
        bundle_t     b;
        logic [31:0] d2;
        b  = make_bundle(32'h2000, 5'd7, 5'd8, 5'd0, 5'd0, 5'd1, 1'b0);
        d2 = lcg();
        @(posedge clk);
        id_bundle   <= b;
        reg_readygo <= 1'b1;
        wb[0]       <= '{we: 1'b1, addr: 5'd7, data: lcg()};
        wb[1]       <= '{we: 1'b1, addr: 5'd7, data: lcg()};
        wb[2]       <= '{we: 1'b1, addr: 5'd7, data: d2};
        @(posedge clk);
        reg_readygo <= 1'b0;
        wb          <= '0;
        @(negedge clk);
        check_val("priority_operand", d2, ex_operands[0].rj_data);
        drain();
        // The stored value must also be port 2's
        b = make_bundle(32'h2010, 5'd7, 5'd0, 5'd0, 5'd0, 5'd1, 1'b0);
        load_bundle(b, 1'b0);
        check_val("priority_stored", d2, ex_operands[0].rj_data);
        drain();
    endtask

    task automatic test_back_pressure();
        bundle_t a;
        bundle_t b;
        a = make_bundle(32'h3000, 5'd0, 5'd0, 5'd0, 5'd0, 5'd1, 1'b0);
        b = make_bundle(32'h3010, 5'd0, 5'd0, 5'd0, 5'd0, 5'd1, 1'b0);
        load_bundle(a, 1'b1);
        @(posedge clk);
        id_bundle   <= b;
        reg_readygo <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_val("bp_allowin", 32'd0, 32'(reg_allowin));
            check_val("bp_hold_pc", a.lanes[0].pc, ex_bundle.lanes[0].pc);
        end
        @(posedge clk);
        ex_allowin <= 1'b1;
        @(negedge clk);
        check_val("bp_release", 32'd1, 32'(reg_allowin));
        check_val("bp_still_a", a.lanes[0].pc, ex_bundle.lanes[0].pc);
        @(posedge clk);
        reg_readygo <= 1'b0;
        @(negedge clk);
        check_val("bp_next_pc", b.lanes[0].pc, ex_bundle.lanes[0].pc);
        drain();
    endtask

    task automatic test_hold_patch();
        bundle_t     b;
        logic [31:0] v;
        b = make_bundle(32'h4000, 5'd3, 5'd4, 5'd5, 5'd6, 5'd1, 1'b0);
        v = lcg();
        load_bundle(b, 1'b1);
        @(posedge clk);
        wb[1] <= '{we: 1'b1, addr: 5'd5, data: v};
        @(posedge clk);
        wb <= '0;
        @(negedge clk);
        check_val("patch_hit", v, ex_operands[1].rj_data);
        check_operands("patch_others", b);
        drain();
    endtask

    task automatic test_load_use();
        bundle_t     l;
        bundle_t     d;
        logic [31:0] val;
        l   = make_bundle(32'h5000, 5'd0, 5'd0, 5'd0, 5'd0, 5'd9, 1'b1);
        d   = make_bundle(32'h5008, 5'd9, 5'd2, 5'd0, 5'd0, 5'd1, 1'b0);
        val = lcg();
        @(posedge clk);
        id_bundle   <= l;
        reg_readygo <= 1'b1;
        @(posedge clk);
        id_bundle   <= d;   // Loads on the edge where the load fires
        for (int i = 1; i <= LOAD_LATENCY; i++) begin
            @(posedge clk);
            reg_readygo <= 1'b0;
            if (i == LOAD_LATENCY) begin
                wb[2] <= '{we: 1'b1, addr: 5'd9, data: val};
            end
            @(negedge clk);
            check_val("load_stall", 32'd0, 32'(ex_readygo));
        end
        @(posedge clk);
        wb <= '0;
        @(negedge clk);
        check_val("load_resume", 32'd1, 32'(ex_readygo));
        check_val("load_held_pc", d.lanes[0].pc, ex_bundle.lanes[0].pc);
        check_val("load_result", val, ex_operands[0].rj_data);
        drain();
        // A bundle that does not read the load's rd goes straight on
        l = make_bundle(32'h5100, 5'd0, 5'd0, 5'd0, 5'd0, 5'd10, 1'b1);
        d = make_bundle(32'h5108, 5'd11, 5'd12, 5'd13, 5'd14, 5'd1, 1'b0);
        load_bundle(l, 1'b0);
        load_bundle(d, 1'b0);
        check_val("indep_no_stall", 32'd1, 32'(ex_readygo));
        drain();
    endtask

    task automatic test_flush();
        bundle_t l;
        bundle_t d;
        bundle_t n;
        l = make_bundle(32'h6000, 5'd0, 5'd0, 5'd0, 5'd0, 5'd9, 1'b1);
        d = make_bundle(32'h6008, 5'd9, 5'd0, 5'd0, 5'd0, 5'd1, 1'b0);
        n = make_bundle(32'h6010, 5'd9, 5'd9, 5'd0, 5'd0, 5'd1, 1'b0);
        @(posedge clk);
        id_bundle   <= l;
        reg_readygo <= 1'b1;
        @(posedge clk);
        id_bundle   <= d;
        @(posedge clk);
        reg_readygo <= 1'b0;
        flush       <= 1'b1;
        @(negedge clk);
        check_val("flush_waiting", 32'd0, 32'(ex_readygo));
        @(posedge clk);
        flush       <= 1'b0;
        id_bundle   <= n;
        reg_readygo <= 1'b1;
        @(negedge clk);
        check_val("flush_valid", 32'd0, 32'(ex_bundle.valid));
        check_val("flush_zero", 32'd0, 32'(|ex_bundle));
        // Loaded while the flushed load would still be pending
        @(posedge clk);
        reg_readygo <= 1'b0;
        @(negedge clk);
        check_val("flush_next_pc", n.lanes[0].pc, ex_bundle.lanes[0].pc);
        check_val("flush_next_go", 32'd1, 32'(ex_readygo));
        drain();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        seed        = 32'h3402;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        reset       = 1'b1;
        flush       = 1'b0;
        reg_readygo = 1'b0;
        id_bundle   = '0;
        ex_allowin  = 1'b1;
        wb          = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_val("reset_valid", 32'd0, 32'(ex_bundle.valid));
        check_val("reset_readygo", 32'd0, 32'(ex_readygo));

        test_read_after_write();
        test_write_priority();
        test_back_pressure();
        test_hold_patch();
        test_load_use();
        test_flush();

        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/rr_pkg.sv
design/bypass_select.sv
design/reg_file.sv
design/load_timer.sv
design/hazard_fsm.sv
design/rr_ex_reg.sv
design/rr_stage.sv
bench/rr_stage_assert.sv
bench/rr_stage_tb.sv

/* Makefile */
TOP = rr_stage_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

obj_dir/V$(TOP): vlog.f design/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
